/* dv/spu_fixed1_assertions.sv */
`timescale 1ns/1ps

module spu_fixed1_assertions (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::quad_t rt_wb,
	input spu_fx_pkg::reg_addr_t rt_addr_wb,
	input logic reg_write_wb,
	input spu_fx_pkg::reg_addr_t rt_addr_dly,
	input logic reg_write_dly
);

	// every output cleared by a reset edge
	a_reset_clear: assert property (@(posedge clk) $past(reset) |->
		(rt_wb == '0 && rt_addr_wb == '0 && !reg_write_wb && rt_addr_dly == '0 && !reg_write_dly))
		else $error("pipe outputs not cleared after reset");

	a_delay_follows: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (rt_addr_dly == $past(rt_addr_wb) && reg_write_dly == $past(reg_write_wb)))
		else $error("delay stage does not follow the writeback stage");  // forwarding view

	a_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown({rt_wb, rt_addr_wb, reg_write_wb, rt_addr_dly, reg_write_dly}))
		else $error("unknown value on pipe outputs");

endmodule

/* dv/spu_fixed1_tb.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fixed1_tb;
	import spu_fx_pkg::*;

	localparam int MAX_CYCLES = 1000;
	localparam quad_t POS_PAT = {4{32'h7fffffff}};  // max in every word and upper halfword
	localparam quad_t NEG_PAT = {4{32'h80000000}};  // min in every word and upper halfword
	localparam quad_t SIGN_FLIP = 128'h80000000_00000080_00008000_00000000;

	logic clk;
	logic reset;
	fmt_e format;
	logic [`SPU_OP_W-1:0] op;
	reg_addr_t rt_addr;
	quad_t ra;
	quad_t rb;
	logic [`SPU_IMM_W-1:0] imm;
	logic reg_write;
	logic branch_taken;
	quad_t rt_wb;
	reg_addr_t rt_addr_wb;
	logic reg_write_wb;
	reg_addr_t rt_addr_dly;
	logic reg_write_dly;

	integer seed = 39065;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic timed_out = 1'b0;

	spu_fixed1 i_dut (.*);

	bind spu_fixed1 spu_fixed1_assertions i_assertions (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// advance to the n-th falling edge, bounded by the cycle budget
	task automatic step(int n);
		while (n > 0 && !timed_out) begin
			@(negedge clk);
			n--;
			cycles++;
			if (cycles > MAX_CYCLES)
				timed_out = 1'b1;
		end
	endtask

	task automatic check(string name, quad_t exp, quad_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic quad_t rand_quad();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// RI10 operand: byte forms replicate imm[7:0], wider forms sign extend imm[9:0]
	function automatic quad_t imm_operand(int w, logic [`SPU_IMM_W-1:0] im);
		quad_t r;
		quad_t mask;
		longint v;
		r = '0;
		mask = (quad_t'(1) << w) - 1;
		v = (w == 8) ? longint'(im[7:0]) : longint'(im[9:0]);
		if (w != 8 && im[9])
			v = v - 1024;
		for (int l = 0; l < 128 / w; l++)
			r = r | ((quad_t'(v) & mask) << (l * w));
		return r;
	endfunction

	// per-lane model of the pipe result
	function automatic quad_t model(alu_func_e f, int w, quad_t a, quad_t b);
		quad_t r;
		quad_t mask;
		longint ua, ub, sa, sb, v, lim;
		r = '0;
		mask = (quad_t'(1) << w) - 1;
		lim = longint'(1) << (w - 1);
		for (int l = 0; l < 128 / w; l++) begin
			ua = longint'((a >> (l * w)) & mask);
			ub = longint'((b >> (l * w)) & mask);
			sa = (ua >= lim) ? ua - 2 * lim : ua;
			sb = (ub >= lim) ? ub - 2 * lim : ub;
			case (f)
				func_add: v = sa + sb;
				func_sub_from: v = sb - sa;
				func_and: v = ua & ub;
				func_or: v = ua | ub;
				func_xor: v = ua ^ ub;
				func_nand: v = ~(ua & ub);
				func_ceq: v = (ua == ub) ? -1 : 0;
				func_cgt: v = (sa > sb) ? -1 : 0;
				default: v = (ua > ub) ? -1 : 0;  // unsigned greater
			endcase
			if ((f == func_add || f == func_sub_from) && v > lim - 1)
				v = lim - 1;
			if ((f == func_add || f == func_sub_from) && v < -lim)
				v = -lim;
			r = r | ((quad_t'(v) & mask) << (l * w));
		end
		return r;
	endfunction

	task automatic drive(fmt_e f, logic [10:0] o, reg_addr_t addr, quad_t a, quad_t b,
			logic [`SPU_IMM_W-1:0] im, logic wr, logic br);
		format = f;
		op = o;
		rt_addr = addr;
		ra = a;
		rb = b;
		imm = im;
		reg_write = wr;
		branch_taken = br;
	endtask

	// one instruction through writeback
	task automatic exec(string name, fmt_e f, logic [10:0] o, alu_func_e fn, int w,
			quad_t a, quad_t b, logic [`SPU_IMM_W-1:0] im);
		quad_t exp;
		reg_addr_t addr;
		addr = $random(seed);
		exp = model(fn, w, a, (f == fmt_ri10) ? imm_operand(w, im) : b);
		drive(f, o, addr, a, b, im, 1'b1, 1'b0);
		step(1);
		check(name, exp, rt_wb);
		check({name, " addr"}, addr, rt_addr_wb);
		check({name, " write"}, 1'b1, reg_write_wb);
	endtask

	task automatic saturating_add_sub();
		rr_op_e ops [4] = '{rr_ah, rr_a, rr_sfh, rr_sf};
		quad_t pa [4] = '{POS_PAT, NEG_PAT, NEG_PAT, POS_PAT};  // overflow both ways
		quad_t pb [4] = '{POS_PAT, NEG_PAT, POS_PAT, NEG_PAT};
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 8; k++)
				exec("sat_arith", fmt_rr, ops[i], (i < 2) ? func_add : func_sub_from,
					(i % 2) ? 32 : 16, (k < 4) ? pa[k] : rand_quad(),
					(k < 4) ? pb[k] : rand_quad(), '0);
		end
	endtask

	task automatic bitwise_ops();
		rr_op_e rr_ops [4] = '{rr_and, rr_or, rr_xor, rr_nand};
		alu_func_e rr_f [4] = '{func_and, func_or, func_xor, func_nand};
		ri10_op_e ri_ops [9] = '{ri_andbi, ri_andhi, ri_andi, ri_orbi, ri_orhi, ri_ori,
			ri_xorbi, ri_xorhi, ri_xori};
		alu_func_e ri_f [3] = '{func_and, func_or, func_xor};
		for (int i = 0; i < 4; i++) begin
			for (int k = 0; k < 3; k++)
				exec("bitwise_rr", fmt_rr, rr_ops[i], rr_f[i], 8, rand_quad(), rand_quad(), '0);
		end
		for (int i = 0; i < 9; i++) begin
			for (int k = 0; k < 3; k++)
				exec("bitwise_ri10", fmt_ri10, {3'b000, ri_ops[i]}, ri_f[i / 3], 8 << (i % 3),
					rand_quad(), rand_quad(), $random(seed));
		end
	endtask

	task automatic lane_compares();
		rr_op_e rr_ops [9] = '{rr_ceqb, rr_ceqh, rr_ceq, rr_cgtb, rr_cgth, rr_cgt,
			rr_clgtb, rr_clgth, rr_clgt};
		ri10_op_e ri_ops [9] = '{ri_ceqbi, ri_ceqhi, ri_ceqi, ri_cgtbi, ri_cgthi, ri_cgti,
			ri_clgtbi, ri_clgthi, ri_clgti};
		alu_func_e fs [3] = '{func_ceq, func_cgt, func_clgt};
		quad_t a;
		logic [`SPU_IMM_W-1:0] im;
		for (int i = 0; i < 9; i++) begin
			for (int k = 0; k < 3; k++) begin
				// k = 0 equal, 1 differs in some sign bits only, 2 random
				a = rand_quad();
				exec("compare_rr", fmt_rr, rr_ops[i], fs[i / 3], 8 << (i % 3), a,
					(k == 0) ? a : (k == 1) ? a ^ SIGN_FLIP : rand_quad(), '0);
				im = $random(seed);
				a = imm_operand(8 << (i % 3), im);
				a = (k == 0) ? a : (k == 1) ? a ^ SIGN_FLIP : rand_quad();
				exec("compare_ri10", fmt_ri10, {3'b000, ri_ops[i]}, fs[i / 3], 8 << (i % 3),
					a, rand_quad(), im);
			end
		end
	endtask

	task automatic immediate_add_sub();
		ri10_op_e ops [4] = '{ri_ahi, ri_ai, ri_sfhi, ri_sfi};
		logic [`SPU_IMM_W-1:0] imms [4] = '{18'h001ff, 18'h00200, 18'h003ff, 18'h00005};
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 12; j++)
				exec("imm_arith", fmt_ri10, {3'b000, ops[i]}, (i < 2) ? func_add : func_sub_from,
					(i % 2) ? 32 : 16, (j % 3 == 0) ? POS_PAT : (j % 3 == 1) ? NEG_PAT :
					rand_quad(), rand_quad(), imms[j / 3]);
		end
	endtask

	task automatic kill_cases();
		fmt_e fmts [4] = '{fmt_rr, fmt_rr, fmt_e'(3'd2), fmt_rr};  // nop, bad op, bad fmt, branch
		logic [10:0] ops [4] = '{11'd0, 11'h7ff, rr_a, rr_a};
		for (int i = 0; i < 4; i++) begin
			drive(fmts[i], ops[i], 7'h55 + i, rand_quad(), rand_quad(), '0, 1'b1, i == 3);
			step(1);
			check("kill result", '0, rt_wb);
			check("kill addr", '0, rt_addr_wb);
			check("kill write", '0, reg_write_wb);
			drive(fmt_rr, 11'd0, '0, '0, '0, '0, 1'b0, 1'b0);
			step(1);
			check("kill delay addr", '0, rt_addr_dly);
			check("kill delay write", '0, reg_write_dly);
		end
	endtask

	task automatic back_to_back();
		reg_addr_t addrs [3] = '{7'd10, 7'd11, 7'd12};
		quad_t as [3];
		quad_t bs [3];
		for (int i = 0; i < 3; i++) begin
			as[i] = rand_quad();
			bs[i] = rand_quad();
		end
		for (int i = 0; i < 4; i++) begin
			if (i < 3)
				drive(fmt_rr, rr_xor, addrs[i], as[i], bs[i], '0, i != 1, 1'b0);
			else
				drive(fmt_rr, 11'd0, '0, '0, '0, '0, 1'b0, 1'b0);
			step(1);
			if (i < 3) begin
				check("b2b result", model(func_xor, 8, as[i], bs[i]), rt_wb);
				check("b2b addr", addrs[i], rt_addr_wb);
				check("b2b write", i != 1, reg_write_wb);
			end
			if (i > 0) begin
				check("b2b delay addr", addrs[i - 1], rt_addr_dly);
				check("b2b delay write", (i - 1) != 1, reg_write_dly);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		drive(fmt_rr, 11'd0, '0, '0, '0, '0, 1'b0, 1'b0);
		step(4);
		reset = 1'b0;
		check("reset wb", '0, rt_wb);
		saturating_add_sub();
		bitwise_ops();
		lane_compares();
		immediate_add_sub();
		kill_cases();
		back_to_back();
		if (timed_out)
			$display("timeout: cycle limit of %0d reached before the tests finished", MAX_CYCLES);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hw/spu_fixed1.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fixed1 (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::fmt_e format,
	input logic [`SPU_OP_W-1:0] op,
	input spu_fx_pkg::reg_addr_t rt_addr,
	input spu_fx_pkg::quad_t ra,
	input spu_fx_pkg::quad_t rb,
	input logic [`SPU_IMM_W-1:0] imm,
	input logic reg_write,
	input logic branch_taken,
	output spu_fx_pkg::quad_t rt_wb,
	output spu_fx_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output spu_fx_pkg::reg_addr_t rt_addr_dly,
	output logic reg_write_dly
);
	import spu_fx_pkg::*;

	alu_func_e func;
	lane_size_e lane_size;
	logic use_imm;
	logic issue_valid;
	quad_t operand_b;  // rb or expanded immediate
	quad_t arith_result;
	quad_t logic_result;

	spu_fx_decode i_decode (
		.format(format),
		.op(op),
		.branch_taken(branch_taken),
		.func(func),
		.lane_size(lane_size),
		.use_imm(use_imm),
		.issue_valid(issue_valid)
	);

	spu_fx_imm_expand i_imm_expand (
		.rb(rb),
		.imm(imm),
		.lane_size(lane_size),
		.use_imm(use_imm),
		.operand_b(operand_b)
	);

	spu_fx_arith i_arith (
		.ra(ra),
		.operand_b(operand_b),
		.func(func),
		.lane_size(lane_size),
		.arith_result(arith_result)
	);

	spu_fx_logic_cmp i_logic_cmp (
		.ra(ra),
		.operand_b(operand_b),
		.func(func),
		.lane_size(lane_size),
		.logic_result(logic_result)
	);

	spu_fx_result_pipe i_result_pipe (
		.clk(clk),
		.reset(reset),
		.arith_result(arith_result),
		.logic_result(logic_result),
		.func(func),
		.issue_valid(issue_valid),
		.rt_addr(rt_addr),
		.reg_write(reg_write),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb),
		.rt_addr_dly(rt_addr_dly),
		.reg_write_dly(reg_write_dly)
	);

endmodule

/* hw/spu_fx_arith.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fx_arith (
	input spu_fx_pkg::quad_t ra,
	input spu_fx_pkg::quad_t operand_b,
	input spu_fx_pkg::alu_func_e func,
	input spu_fx_pkg::lane_size_e lane_size,
	output spu_fx_pkg::quad_t arith_result
);
	import spu_fx_pkg::*;

	localparam int QW = `SPU_QUAD_W;

	logic sub;
	quad_t sat_res [2];  // [0] halfword lanes, [1] word lanes

	assign sub = (func == func_sub_from);

	for (genvar s = 0; s < 2; s++) begin : g_size
		localparam int W = 16 << s;
		for (genvar l = 0; l < QW / W; l++) begin : g_lane
			logic signed [W-1:0] a;
			logic signed [W-1:0] b;
			logic signed [W:0] sum;  // one guard bit for overflow

			assign a = ra[l*W +: W];
			assign b = operand_b[l*W +: W];
			assign sum = sub ? (b - a) : (a + b);

			// guard and sign bit disagree on overflow, guard gives direction
			assign sat_res[s][l*W +: W] = (sum[W] == sum[W-1]) ? sum[W-1:0] :
				(sum[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}});
		end
	end

	assign arith_result = (lane_size == lane_word) ? sat_res[1] : sat_res[0];

endmodule

/* hw/spu_fx_decode.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fx_decode (
	input spu_fx_pkg::fmt_e format,
	input logic [`SPU_OP_W-1:0] op,
	input logic branch_taken,
	output spu_fx_pkg::alu_func_e func,
	output spu_fx_pkg::lane_size_e lane_size,
	output logic use_imm,
	output logic issue_valid
);
	import spu_fx_pkg::*;

	rr_op_e rr_op;
	ri10_op_e ri_op;
	logic op_known;

	assign rr_op = rr_op_e'(op);
	assign ri_op = ri10_op_e'(op[7:0]);  // upper opcode bits ignored for RI10

	always_comb begin
		func = func_and;
		lane_size = lane_byte;
		use_imm = 1'b0;
		op_known = 1'b1;
		case (format)
			fmt_rr: begin
				case (rr_op)
					rr_ah, rr_a: func = func_add;
					rr_sfh, rr_sf: func = func_sub_from;
					rr_and: func = func_and;
					rr_or: func = func_or;
					rr_xor: func = func_xor;
					rr_nand: func = func_nand;
					rr_ceqb, rr_ceqh, rr_ceq: func = func_ceq;
					rr_cgtb, rr_cgth, rr_cgt: func = func_cgt;
					rr_clgtb, rr_clgth, rr_clgt: func = func_clgt;
					default: op_known = 1'b0;  // nop and unknown opcodes
				endcase
				case (rr_op)
					rr_ah, rr_sfh, rr_ceqh, rr_cgth, rr_clgth: lane_size = lane_half;
					rr_a, rr_sf, rr_ceq, rr_cgt, rr_clgt: lane_size = lane_word;
					default: lane_size = lane_byte;  // logic ops don't care
				endcase
			end
			fmt_ri10: begin
				use_imm = 1'b1;
				case (ri_op)
					ri_ahi, ri_ai: func = func_add;
					ri_sfhi, ri_sfi: func = func_sub_from;
					ri_andbi, ri_andhi, ri_andi: func = func_and;
					ri_orbi, ri_orhi, ri_ori: func = func_or;
					ri_xorbi, ri_xorhi, ri_xori: func = func_xor;
					ri_ceqbi, ri_ceqhi, ri_ceqi: func = func_ceq;
					ri_cgtbi, ri_cgthi, ri_cgti: func = func_cgt;
					ri_clgtbi, ri_clgthi, ri_clgti: func = func_clgt;
					default: op_known = 1'b0;
				endcase
				case (ri_op)
					ri_ahi, ri_sfhi, ri_andhi, ri_orhi, ri_xorhi,
					ri_ceqhi, ri_cgthi, ri_clgthi: lane_size = lane_half;
					ri_ai, ri_sfi, ri_andi, ri_ori, ri_xori,
					ri_ceqi, ri_cgti, ri_clgti: lane_size = lane_word;
					default: lane_size = lane_byte;
				endcase
			end
			default: op_known = 1'b0;  // RI16/RI18 and anything else
		endcase
	end

	// a taken branch kills whatever is in the issue slot
	assign issue_valid = op_known & ~branch_taken;

endmodule

/* hw/spu_fx_imm_expand.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fx_imm_expand (
	input spu_fx_pkg::quad_t rb,
	input logic [`SPU_IMM_W-1:0] imm,
	input spu_fx_pkg::lane_size_e lane_size,
	input logic use_imm,
	output spu_fx_pkg::quad_t operand_b
);
	import spu_fx_pkg::*;

	logic [`SPU_IMM10_W-1:0] imm10;
	logic [7:0] imm_byte;
	logic [15:0] imm_half;
	logic [31:0] imm_word;
	quad_t imm_quad;

	assign imm10 = imm[`SPU_IMM10_W-1:0];
	assign imm_byte = imm[7:0];  // byte forms take the low 8 bits as is
	assign imm_half = {{(16 - `SPU_IMM10_W){imm10[`SPU_IMM10_W-1]}}, imm10};
	assign imm_word = {{(32 - `SPU_IMM10_W){imm10[`SPU_IMM10_W-1]}}, imm10};

	always_comb begin
		case (lane_size)
			lane_byte: imm_quad = {(`SPU_QUAD_W / 8){imm_byte}};
			lane_half: imm_quad = {(`SPU_QUAD_W / 16){imm_half}};
			default: imm_quad = {(`SPU_QUAD_W / 32){imm_word}};
		endcase
	end

	assign operand_b = use_imm ? imm_quad : rb;

endmodule

/* hw/spu_fx_logic_cmp.sv */
`timescale 1ns/1ps
`include "spu_fx_cfg.svh"

module spu_fx_logic_cmp (
	input spu_fx_pkg::quad_t ra,
	input spu_fx_pkg::quad_t operand_b,
	input spu_fx_pkg::alu_func_e func,
	input spu_fx_pkg::lane_size_e lane_size,
	output spu_fx_pkg::quad_t logic_result
);
	import spu_fx_pkg::*;

	localparam int QW = `SPU_QUAD_W;

	quad_t cmp_res [3];  // byte, halfword, word masks
	quad_t cmp_sel;

	for (genvar s = 0; s < 3; s++) begin : g_size
		localparam int W = 8 << s;
		for (genvar l = 0; l < QW / W; l++) begin : g_lane
			logic [W-1:0] a;
			logic [W-1:0] b;
			logic hit;

			assign a = ra[l*W +: W];
			assign b = operand_b[l*W +: W];
			assign hit = (func == func_ceq) ? (a == b) :
				(func == func_cgt) ? ($signed(a) > $signed(b)) :
				(a > b);  // clgt
			assign cmp_res[s][l*W +: W] = {W{hit}};
		end
	end

	always_comb begin
		case (lane_size)
			lane_byte: cmp_sel = cmp_res[0];
			lane_half: cmp_sel = cmp_res[1];
			default: cmp_sel = cmp_res[2];
		endcase
	end

	// bitwise ops ignore lanes
	always_comb begin
		case (func)
			func_and: logic_result = ra & operand_b;
			func_or: logic_result = ra | operand_b;
			func_xor: logic_result = ra ^ operand_b;
			func_nand: logic_result = ~(ra & operand_b);
			func_ceq, func_cgt, func_clgt: logic_result = cmp_sel;
			default: logic_result = '0;  // arith funcs, result taken elsewhere
		endcase
	end

endmodule

/* hw/spu_fx_pkg.sv */
`include "spu_fx_cfg.svh"

package spu_fx_pkg;

	typedef logic [`SPU_QUAD_W-1:0] quad_t;  // lane 0 in the low bits
	typedef logic [`SPU_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [`SPU_FMT_W-1:0] {
		fmt_rr = 3'd0,
		fmt_ri10 = 3'd4
	} fmt_e;

	// RR opcodes, full 11 bit field
	typedef enum logic [`SPU_OP_W-1:0] {
		rr_ah = 11'b00011001000,
		rr_a = 11'b00011000000,
		rr_sfh = 11'b00001001000,
		rr_sf = 11'b00001000000,
		rr_and = 11'b00011000001,
		rr_or = 11'b00001000001,
		rr_xor = 11'b01001000001,
		rr_nand = 11'b00011001001,
		rr_ceqb = 11'b01111010000,
		rr_ceqh = 11'b01111001000,
		rr_ceq = 11'b01111000000,
		rr_cgtb = 11'b01001010000,
		rr_cgth = 11'b01001001000,
		rr_cgt = 11'b01001000000,
		rr_clgtb = 11'b01011010000,
		rr_clgth = 11'b01011001000,
		rr_clgt = 11'b01011000000
	} rr_op_e;

	// RI10 opcodes, matched against op[7:0]
	typedef enum logic [7:0] {
		ri_ahi = 8'b00011101,
		ri_ai = 8'b00011100,
		ri_sfhi = 8'b00001101,
		ri_sfi = 8'b00001100,
		ri_andbi = 8'b00010110,
		ri_andhi = 8'b00010101,
		ri_andi = 8'b00010100,
		ri_orbi = 8'b00000110,
		ri_orhi = 8'b00000101,
		ri_ori = 8'b00000100,
		ri_xorbi = 8'b01000110,
		ri_xorhi = 8'b01000101,
		ri_xori = 8'b01000100,
		ri_ceqbi = 8'b01111110,
		ri_ceqhi = 8'b01111101,
		ri_ceqi = 8'b01111100,
		ri_cgtbi = 8'b01001110,
		ri_cgthi = 8'b01001101,
		ri_cgti = 8'b01001100,
		ri_clgtbi = 8'b01011110,
		ri_clgthi = 8'b01011101,
		ri_clgti = 8'b01011100
	} ri10_op_e;

	typedef enum logic [3:0] {
		func_add,
		func_sub_from,  // operand_b minus ra
		func_and,
		func_or,
		func_xor,
		func_nand,
		func_ceq,
		func_cgt,  // signed
		func_clgt  // unsigned
	} alu_func_e;

	typedef enum logic [1:0] {
		lane_byte,
		lane_half,
		lane_word
	} lane_size_e;

	function automatic logic alu_func_is_arith(alu_func_e func);
		return (func == func_add) || (func == func_sub_from);
	endfunction

endpackage

/* hw/spu_fx_result_pipe.sv */
`timescale 1ns/1ps

module spu_fx_result_pipe (
	input logic clk,
	input logic reset,
	input spu_fx_pkg::quad_t arith_result,
	input spu_fx_pkg::quad_t logic_result,
	input spu_fx_pkg::alu_func_e func,
	input logic issue_valid,
	input spu_fx_pkg::reg_addr_t rt_addr,
	input logic reg_write,
	output spu_fx_pkg::quad_t rt_wb,
	output spu_fx_pkg::reg_addr_t rt_addr_wb,
	output logic reg_write_wb,
	output spu_fx_pkg::reg_addr_t rt_addr_dly,
	output logic reg_write_dly
);
	import spu_fx_pkg::*;

	quad_t result;

	assign result = alu_func_is_arith(func) ? arith_result : logic_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_wb <= '0;
			rt_addr_wb <= '0;
			reg_write_wb <= 1'b0;
			rt_addr_dly <= '0;
			reg_write_dly <= 1'b0;
		end else begin
			// killed instructions leave a bubble of zeros
			rt_wb <= issue_valid ? result : '0;
			rt_addr_wb <= issue_valid ? rt_addr : '0;
			reg_write_wb <= issue_valid & reg_write;
			// delay stage keeps the target visible for forwarding
			rt_addr_dly <= rt_addr_wb;
			reg_write_dly <= reg_write_wb;
		end
	end

endmodule

/* include/spu_fx_cfg.svh */
`ifndef SPU_FX_CFG_SVH
`define SPU_FX_CFG_SVH

// datapath widths of the fixed-point pipe
`define SPU_QUAD_W 128  // one quadword register
`define SPU_ADDR_W 7  // 128 entry register file
`define SPU_OP_W 11  // widest opcode field (RR)
`define SPU_FMT_W 3

// the RI10 immediate sits in the low bits of the immediate field
`define SPU_IMM_W 18
`define SPU_IMM10_W 10

`endif

/* spu_fixed1.f */
+incdir+include
hw/spu_fx_pkg.sv
hw/spu_fx_decode.sv
hw/spu_fx_imm_expand.sv
hw/spu_fx_arith.sv
hw/spu_fx_logic_cmp.sv
hw/spu_fx_result_pipe.sv
hw/spu_fixed1.sv
dv/spu_fixed1_assertions.sv
dv/spu_fixed1_tb.sv
